/* Makefile */
VERILATOR ?= verilator
TOP       ?= coreTb
BUILD     ?= build
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASSTEXT  ?= ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASSTEXT)'

clean:
	rm -rf $(BUILD)

/* dv/coreChk.sv */
`timescale 1ns/1ps

module coreChk (
    input logic        clk,
    input logic        reset_n,
    input logic        imArvalid,
    input logic        imArready,
    input logic [31:0] imAraddr,
    input logic        dmAwvalid,
    input logic        dmAwready,
    input logic [31:0] dmAwaddr,
    input logic        dmWvalid,
    input logic        dmWready,
    input logic [31:0] dmWdata,
    input logic        dmArvalid,
    input logic        dmArready,
    input logic [31:0] dmAraddr,
    input logic        halt
);
    int fails = 0;  // Failed assertion count

    imArHold: assert property (@(posedge clk) disable iff (!reset_n)
        imArvalid && !imArready |=> imArvalid && $stable(imAraddr))
        else begin
            fails++;
            $error("instruction AR dropped or changed before ready");
        end
    awHold: assert property (@(posedge clk) disable iff (!reset_n)
        dmAwvalid && !dmAwready |=> dmAwvalid && $stable(dmAwaddr))
        else begin
            fails++;
            $error("data AW dropped or changed before ready");
        end
    wHold: assert property (@(posedge clk) disable iff (!reset_n)
        dmWvalid && !dmWready |=> dmWvalid && $stable(dmWdata))
        else begin
            fails++;
            $error("data W dropped or changed before ready");
        end
    dmArHold: assert property (@(posedge clk) disable iff (!reset_n)
        dmArvalid && !dmArready |=> dmArvalid && $stable(dmAraddr))
        else begin
            fails++;
            $error("data AR dropped or changed before ready");
        end
    haltSticky: assert property (@(posedge clk) disable iff (!reset_n) halt |=> halt)
        else begin
            fails++;
            $error("halt fell without reset");
        end
    // No new read starts once halted
    noFetchHalted: assert property (@(posedge clk) disable iff (!reset_n)
        halt && (!imArvalid || imArready) |=> !imArvalid)
        else begin
            fails++;
            $error("instruction read issued while halted");
        end

endmodule

/* dv/coreTb.sv */
`timescale 1ns/1ps

module coreTb;
    logic        clk;
    logic        reset_n = 1'b0;
    logic        imArvalid, imRready, dmAwvalid, dmWvalid, dmBready, dmArvalid, dmRready, halt;
    logic [31:0] imAraddr, dmAwaddr, dmWdata, dmAraddr;
    logic [3:0]  dmWstrb;
    logic        imArready = 1'b0;
    logic        imRvalid = 1'b0;
    logic [31:0] imRdata = '0;
    logic [1:0]  imRresp = 2'b00;
    logic        dmAwready = 1'b0;
    logic        dmWready = 1'b0;
    logic        dmBvalid = 1'b0;
    logic [1:0]  dmBresp = 2'b00;
    logic        dmArready = 1'b0;
    logic        dmRvalid = 1'b0;
    logic [31:0] dmRdata = '0;
    logic [1:0]  dmRresp = 2'b00;

    integer      seed = 32'h106b12ce;
    logic        slow = 1'b0;  // Random slave delays
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] expMem [256];
    logic [31:0] prog [$];
    logic [7:0]  arQ [$];
    logic [7:0]  awIdx, rdIdx;
    logic [31:0] wData;
    logic        awGot, wGot, arGot, prevArv, prevArFire, prevHalt;
    int          writesAfterHalt, lateReads, errors, passed, failed;

    tbClock clk0 (.clk(clk));

    tenyrCore dut0 (.*);

    bind tenyrCore coreChk chk0 (.*);

    function bit readyDraw();
        integer r;
        r = $random(seed);
        return !slow || r[0];
    endfunction

    function logic [31:0] enc(input bit k, input bit st, input bit dr, input logic [3:0] z,
                              input logic [3:0] x, input logic [3:0] y, input logic [3:0] op,
                              input int imm);
        return {1'b0, k, st, dr, z, x, y, op, imm[11:0]};
    endfunction

    // Comparisons give all ones for true
    function logic [31:0] aluRef(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b);
        case (op)
            4'h0: return a | b;
            4'h1: return a & b;
            4'h2: return a + b;
            4'h3: return a * b;
            4'h5: return (b >= 32) ? 32'h0 : a << b[4:0];
            4'h6: return ($signed(a) < $signed(b)) ? 32'hffff_ffff : 32'h0;
            4'h7: return (a == b) ? 32'hffff_ffff : 32'h0;
            4'h8: return ($signed(a) > $signed(b)) ? 32'hffff_ffff : 32'h0;
            4'h9: return a & ~b;
            4'ha: return a ^ b;
            4'hb: return a - b;
            4'hc: return ~(a ^ b);
            4'hd: return (b >= 32) ? 32'h0 : a >> b[4:0];
            4'he: return (a != b) ? 32'hffff_ffff : 32'h0;
            default: return 32'h0;
        endcase
    endfunction

    // Instruction memory slave answering reads in order
    always @(posedge clk) begin
        if (!reset_n) begin
            arQ.delete();
            imRvalid <= 1'b0;
            imArready <= 1'b0;
            prevArv = 1'b0;
            prevArFire = 1'b0;
            prevHalt = 1'b0;
        end else begin
            if (imArvalid && (!prevArv || prevArFire) && prevHalt)
                lateReads++;  // New request after halt
            prevArv = imArvalid;
            prevArFire = imArvalid && imArready;
            prevHalt = halt;
            if (imArvalid && imArready)
                arQ.push_back(imAraddr[9:2]);
            imArready <= readyDraw();
            if (imRvalid && !imRready)
                imRvalid <= 1'b1;
            else if (arQ.size() > 0 && readyDraw()) begin
                imRvalid <= 1'b1;
                imRdata <= imem[arQ.pop_front()];
            end else
                imRvalid <= 1'b0;
        end
    end

    // Data memory slave
    always @(posedge clk) begin
        if (!reset_n) begin
            awGot = 1'b0;
            wGot = 1'b0;
            arGot = 1'b0;
            dmBvalid <= 1'b0;
            dmRvalid <= 1'b0;
            dmAwready <= 1'b0;
            dmWready <= 1'b0;
            dmArready <= 1'b0;
        end else begin
            if (dmBvalid && dmBready)
                dmBvalid <= 1'b0;
            if (dmRvalid && dmRready)
                dmRvalid <= 1'b0;
            if (dmAwvalid && dmAwready) begin
                awGot = 1'b1;
                awIdx = dmAwaddr[9:2];
            end
            if (dmWvalid && dmWready) begin
                wGot = 1'b1;
                wData = dmWdata;
                assert (dmWstrb === 4'hf) else begin
                    $display("error %0t: write strobe is %h, expected f", $time, dmWstrb);
                    errors++;
                end
            end
            if (dmArvalid && dmArready) begin
                arGot = 1'b1;
                rdIdx = dmAraddr[9:2];
            end
            if (awGot && wGot && readyDraw()) begin
                dmem[awIdx] = wData;
                if (halt)
                    writesAfterHalt++;
                awGot = 1'b0;
                wGot = 1'b0;
                dmBvalid <= 1'b1;
            end
            if (arGot && readyDraw()) begin
                dmRdata <= dmem[rdIdx];
                dmRvalid <= 1'b1;
                arGot = 1'b0;
            end
            dmAwready <= readyDraw();
            dmWready <= readyDraw();
            dmArready <= readyDraw();
        end
    end

    task automatic clearMem();
        prog.delete();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = (32'h0101_0101 * i) ^ 32'hc3a5_0000;
            expMem[i] = dmem[i];
        end
    endtask

    task automatic runProg(input string name);
        int n;
        int errBefore;
        errBefore = errors;
        for (int i = 0; i < 256; i++)
            imem[i] = (i < prog.size()) ? prog[i] : 32'(i);
        writesAfterHalt = 0;
        lateReads = 0;
        @(posedge clk) reset_n <= 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        n = 0;
        while (!halt && n < 4000) begin
            @(posedge clk);
            n++;
        end
        assert (halt) else begin
            $display("timeout waiting for halt in test %s", name);
            errors++;
        end
        repeat (6) @(posedge clk);  // Window for stray writes
        for (int i = 0; i < 256; i++) begin
            assert (dmem[i] === expMem[i]) else begin
                $display("error %0t: %s word %0d is %h, expected %h",
                         $time, name, i, dmem[i], expMem[i]);
                errors++;
            end
        end
        assert (writesAfterHalt == 0) else begin
            $display("error %0t: %s wrote data after halt", $time, name);
            errors++;
        end
        assert (lateReads == 0) else begin
            $display("error %0t: %s fetched after halt", $time, name);
            errors++;
        end
        if (errors == errBefore) begin
            passed++;
            $display("test %s (slow %0d): ok", name, slow);
        end else begin
            failed++;
            $display("test %s (slow %0d): failed", name, slow);
        end
    endtask

    task automatic aluTest();
        int a;
        int b;
        a = -1500;
        b = 5;
        clearMem();
        prog.push_back(enc(0, 0, 0, 1, 0, 0, 4'h0, a));
        prog.push_back(enc(0, 0, 0, 2, 0, 0, 4'h0, b));
        for (int op = 0; op < 15; op++) begin
            if (op != 4) begin
                prog.push_back(enc(0, 0, 0, 3, 1, 2, op[3:0], 0));
                prog.push_back(enc(0, 1, 1, 3, 0, 0, 4'h0, 16 + op));
                expMem[16 + op] = aluRef(op[3:0], a, b);
                prog.push_back(enc(0, 0, 0, 3, 2, 1, op[3:0], 0));
                prog.push_back(enc(0, 1, 1, 3, 0, 0, 4'h0, 32 + op));
                expMem[32 + op] = aluRef(op[3:0], b, a);
            end
        end
        prog.push_back(enc(1, 0, 0, 4, 1, 2, 4'hb, 7));  // X - imm + Y
        prog.push_back(enc(0, 1, 1, 4, 0, 0, 4'h0, 48));
        expMem[48] = a - 7 + b;
        prog.push_back(enc(0, 0, 0, 5, 1, 2, 4'h2, 100));
        prog.push_back(enc(0, 1, 1, 5, 0, 0, 4'h0, 49));
        expMem[49] = a + b + 100;
        prog.push_back(32'hffff_ffff);
        runProg("alu");
    endtask

    task automatic memTest();
        logic [31:0] v32;
        logic [31:0] v33;
        clearMem();
        v32 = dmem[32];
        v33 = dmem[33];
        prog.push_back(enc(0, 0, 1, 5, 0, 0, 4'h0, 32));
        prog.push_back(enc(0, 0, 1, 6, 0, 0, 4'h0, 33));
        prog.push_back(enc(0, 0, 0, 7, 5, 6, 4'h2, 1));
        prog.push_back(enc(0, 1, 1, 7, 0, 0, 4'h0, 40));  // mem[rhs] = Z
        expMem[40] = v32 + v33 + 1;
        prog.push_back(enc(0, 0, 0, 8, 0, 0, 4'h0, 41));
        prog.push_back(enc(0, 1, 0, 8, 7, 5, 4'ha, 0));   // mem[Z] = rhs
        expMem[41] = (v32 + v33 + 1) ^ v32;
        prog.push_back(enc(1, 0, 1, 9, 8, 0, 4'h2, -8));
        prog.push_back(enc(0, 1, 1, 9, 0, 0, 4'h0, 42));
        expMem[42] = v33;
        prog.push_back(32'hffff_ffff);
        runProg("loadStore");
    endtask

    task automatic branchTest();
        clearMem();
        prog.push_back(enc(0, 0, 0, 10, 0, 0, 4'h0, 'h5a5));
        prog.push_back(enc(0, 0, 0, 15, 15, 0, 4'h2, 2));  // Skips the next two
        prog.push_back(enc(0, 1, 1, 10, 0, 0, 4'h0, 50));
        prog.push_back(enc(0, 1, 1, 10, 0, 0, 4'h0, 50));
        prog.push_back(enc(0, 0, 0, 12, 0, 0, 4'h0, 5));
        prog.push_back(enc(0, 0, 0, 11, 11, 0, 4'h2, 1));
        prog.push_back(enc(0, 0, 0, 13, 11, 12, 4'h6, 0));
        prog.push_back(enc(1, 0, 0, 15, 13, 15, 4'h1, -3));  // Back to the increment
        prog.push_back(enc(0, 1, 1, 11, 0, 0, 4'h0, 51));
        expMem[51] = 32'd5;
        prog.push_back(32'hffff_ffff);
        runProg("branch");
    endtask

    task automatic haltTest();
        clearMem();
        prog.push_back(enc(0, 0, 0, 1, 0, 0, 4'h0, 7));
        prog.push_back(enc(0, 0, 0, 0, 1, 0, 4'h0, 0));
        prog.push_back(enc(0, 1, 1, 0, 0, 0, 4'h0, 60));
        expMem[60] = 32'h0;
        prog.push_back(enc(0, 0, 0, 15, 15, 0, 4'h2, 0));  // Branch to the next word
        prog.push_back(enc(0, 1, 1, 15, 0, 0, 4'h0, 61));
        expMem[61] = 32'd5;
        prog.push_back(32'hffff_ffff);
        prog.push_back(enc(0, 1, 1, 1, 0, 0, 4'h0, 62));
        prog.push_back(enc(0, 1, 1, 1, 0, 0, 4'h0, 63));
        runProg("halt");
    endtask

    initial begin
        for (int pass = 0; pass < 2; pass++) begin
            slow = pass[0];
            aluTest();
            memTest();
            branchTest();
            haltTest();
        end
        $display("tests passed %0d failed %0d, checker failures %0d",
                 passed, failed, dut0.chk0.fails);
        if (failed == 0 && dut0.chk0.fails == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* dv/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;  // 40 ns period

endmodule

/* verilog/execUnit.sv */
`include "tenyr_cfg.svh"
`timescale 1ns/1ps

module execUnit (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     popValid,
    input  tenyrPkg::queueItem_t     popItem,
    input  logic [`TENYR_XLEN-1:0]   valueZ,
    input  logic [`TENYR_XLEN-1:0]   valueX,
    input  logic [`TENYR_XLEN-1:0]   valueY,
    output logic                     popReady,
    output logic [3:0]               indexZ,
    output logic [3:0]               indexX,
    output logic [3:0]               indexY,
    output logic [`TENYR_XLEN-1:0]   nextPc,
    output logic                     writeEn,
    output logic [`TENYR_XLEN-1:0]   writeData,
    output tenyrPkg::redirect_t      redirect,
    output logic                     halt,
    output logic                     dmAwvalid,
    output logic [`TENYR_XLEN-1:0]   dmAwaddr,
    input  logic                     dmAwready,
    output logic                     dmWvalid,
    output logic [`TENYR_XLEN-1:0]   dmWdata,
    output logic [`TENYR_XLEN/8-1:0] dmWstrb,
    input  logic                     dmWready,
    input  logic                     dmBvalid,
    input  logic [1:0]               dmBresp,
    output logic                     dmBready,
    output logic                     dmArvalid,
    output logic [`TENYR_XLEN-1:0]   dmAraddr,
    input  logic                     dmArready,
    input  logic                     dmRvalid,
    input  logic [`TENYR_XLEN-1:0]   dmRdata,
    input  logic [1:0]               dmRresp,
    output logic                     dmRready
);
    typedef enum logic [1:0] {
        idle,
        loadWait,
        storeWait
    } memState_t;

    memState_t                     state;
    tenyrPkg::insnFields_t         insn;
    logic                          active;   // Low through reset and one cycle after
    logic [3:0]                    loadZ;    // Destination of the open load
    logic signed [`TENYR_XLEN-1:0] immExt;
    logic signed [`TENYR_XLEN-1:0] lhs;
    logic signed [`TENYR_XLEN-1:0] right;
    logic [`TENYR_XLEN-1:0]        addend;
    logic [`TENYR_XLEN-1:0]        aluOut;
    logic [`TENYR_XLEN-1:0]        rhs;
    logic [`TENYR_XLEN-1:0]        result;

    wire illegal = &popItem.insn;
    wire popFire = popValid && popReady;
    wire aluFire = popFire && !illegal && !insn.storing && !insn.deref;
    wire loadDone = state == loadWait && dmRvalid;
    wire storeDone = state == storeWait && dmBvalid;
    wire retire = aluFire || loadDone;
    wire busError = (storeDone && dmBresp[1]) || (loadDone && dmRresp[1]);

    assign insn = tenyrPkg::insnFields_t'(popItem.insn);
    assign popReady = active && !halt && state == idle;
    assign indexZ = (state == loadWait) ? loadZ : insn.z;
    assign indexX = insn.x;
    assign indexY = insn.y;
    assign nextPc = popItem.pc + 1'b1;

    assign result = loadDone ? dmRdata : rhs;
    assign writeEn = retire && indexZ != 4'hf;
    assign writeData = result;
    assign redirect = '{valid: retire && indexZ == 4'hf, target: result};  // Writes to r15 branch

    assign dmWstrb = '1;
    assign dmBready = state == storeWait;
    assign dmRready = state == loadWait;

    // Operand order follows the kind bit
    assign immExt = {{(`TENYR_XLEN-12){insn.imm[11]}}, insn.imm};
    assign lhs = valueX;
    assign right = insn.kind ? immExt : valueY;
    assign addend = insn.kind ? valueY : immExt;

    always_comb begin
        case (insn.op)
            tenyrPkg::orOp:   aluOut = lhs | right;
            tenyrPkg::andOp:  aluOut = lhs & right;
            tenyrPkg::addOp:  aluOut = lhs + right;
            tenyrPkg::mulOp:  aluOut = lhs * right;
            tenyrPkg::shlOp:  aluOut = lhs << right;
            tenyrPkg::ltOp:   aluOut = {`TENYR_XLEN{lhs < right}};  // All ones when true
            tenyrPkg::eqOp:   aluOut = {`TENYR_XLEN{lhs == right}};
            tenyrPkg::gtOp:   aluOut = {`TENYR_XLEN{lhs > right}};
            tenyrPkg::andnOp: aluOut = lhs & ~right;
            tenyrPkg::xorOp:  aluOut = lhs ^ right;
            tenyrPkg::subOp:  aluOut = lhs - right;
            tenyrPkg::xnorOp: aluOut = lhs ~^ right;
            tenyrPkg::shrOp:  aluOut = lhs >> right;
            tenyrPkg::neOp:   aluOut = {`TENYR_XLEN{lhs != right}};
            default:          aluOut = '0;  // Reserved ops
        endcase
        rhs = aluOut + addend;
    end

    // Request payload captured at pop, valid only from the next cycle
    always_ff @(posedge clk) begin
        if (popFire) begin
            loadZ <= insn.z;
            dmAwaddr <= {(insn.deref ? rhs[`TENYR_XLEN-3:0] : valueZ[`TENYR_XLEN-3:0]), 2'b00};
            dmWdata <= insn.deref ? valueZ : rhs;
            dmAraddr <= {rhs[`TENYR_XLEN-3:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= idle;
            active <= 1'b0;
            halt <= 1'b0;
            dmAwvalid <= 1'b0;
            dmWvalid <= 1'b0;
            dmArvalid <= 1'b0;
        end else begin
            active <= 1'b1;
            if ((popFire && illegal) || busError)
                halt <= 1'b1;
            case (state)
                idle: begin
                    if (popFire && !illegal && insn.storing) begin
                        dmAwvalid <= 1'b1;  // AW and W together
                        dmWvalid <= 1'b1;
                        state <= storeWait;
                    end else if (popFire && !illegal && insn.deref) begin
                        dmArvalid <= 1'b1;
                        state <= loadWait;
                    end
                end
                storeWait: begin
                    if (dmAwready)
                        dmAwvalid <= 1'b0;
                    if (dmWready)
                        dmWvalid <= 1'b0;
                    if (dmBvalid)
                        state <= idle;
                end
                loadWait: begin
                    if (dmArready)
                        dmArvalid <= 1'b0;
                    if (dmRvalid)
                        state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* verilog/fetchUnit.sv */
`include "tenyr_cfg.svh"
`timescale 1ns/1ps

module fetchUnit (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  tenyrPkg::redirect_t                     redirect,
    input  logic                                    halt,
    input  logic                                    imArready,
    input  logic                                    imRvalid,
    input  logic [`TENYR_XLEN-1:0]                  imRdata,
    input  logic [1:0]                              imRresp,
    input  logic                                    pushReady,
    input  logic [$clog2(`TENYR_QUEUE_DEPTH+1)-1:0] freeSlots,
    output logic                                    imArvalid,
    output logic [`TENYR_XLEN-1:0]                  imAraddr,
    output logic                                    imRready,
    output logic                                    pushValid,
    output tenyrPkg::queueItem_t                    pushItem
);
    localparam int SlotW = $bits(freeSlots);

    logic [`TENYR_XLEN-1:0] fetchPc;     // Next word to request
    logic [`TENYR_XLEN-1:0] arPc;        // Word on the AR channel
    logic [`TENYR_XLEN-1:0] addrQ [2];   // Addresses of outstanding reads
    logic                   wrSel;
    logic                   rdSel;
    logic [1:0]             inFlight;
    logic [1:0]             dropCount;   // Stale responses still to come

    wire arFire = imArvalid && imArready;
    wire rFire = imRvalid && imRready;
    wire stale = redirect.valid || dropCount != 2'd0;
    wire [1:0] inFlightNext = inFlight + 2'(arFire) - 2'(rFire);
    wire [1:0] reserved = inFlight + 2'(arFire);
    wire [`TENYR_XLEN-1:0] issuePc = redirect.valid ? redirect.target : fetchPc;

    // Every outstanding read keeps a queue slot for its response
    wire canIssue = !halt && pushReady && inFlightNext < 2'd2 && freeSlots > SlotW'(reserved);

    assign imRready = 1'b1;
    assign imAraddr = {arPc[`TENYR_XLEN-3:0], 2'b00};
    assign pushValid = rFire && !stale;
    // A failed read becomes an all-ones word so the core halts on it
    assign pushItem = '{pc: addrQ[rdSel], insn: imRresp[1] ? '1 : imRdata};

    always_ff @(posedge clk) begin
        if (arFire)
            addrQ[wrSel] <= arPc;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            imArvalid <= 1'b0;
            arPc <= `TENYR_RESET_VECTOR;
            fetchPc <= `TENYR_RESET_VECTOR;
            wrSel <= 1'b0;
            rdSel <= 1'b0;
            inFlight <= 2'd0;
            dropCount <= 2'd0;
        end else begin
            inFlight <= inFlightNext;
            if (arFire)
                wrSel <= !wrSel;
            if (rFire)
                rdSel <= !rdSel;
            // A pending AR still goes out and its data is dropped too
            if (redirect.valid)
                dropCount <= inFlight + 2'(imArvalid) - 2'(rFire);
            else if (rFire && dropCount != 2'd0)
                dropCount <= dropCount - 2'd1;
            if (redirect.valid)
                fetchPc <= redirect.target;
            if (!imArvalid || imArready) begin
                imArvalid <= canIssue;
                if (canIssue) begin
                    arPc <= issuePc;
                    fetchPc <= issuePc + 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/insnQueue.sv */
`include "tenyr_cfg.svh"
`timescale 1ns/1ps

module insnQueue #(
    parameter int DEPTH = `TENYR_QUEUE_DEPTH
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         flush,
    input  logic                         pushValid,
    input  tenyrPkg::queueItem_t         pushItem,
    input  logic                         popReady,
    output logic                         pushReady,
    output logic                         popValid,
    output tenyrPkg::queueItem_t         popItem,
    output logic [$clog2(DEPTH+1)-1:0]   freeSlots
);
    localparam int PtrW = $clog2(DEPTH);
    localparam int CntW = $clog2(DEPTH + 1);

    tenyrPkg::queueItem_t slots [DEPTH];
    logic [PtrW-1:0]      rdPtr;
    logic [PtrW-1:0]      wrPtr;
    logic [CntW-1:0]      count;

    wire doPush = pushValid && pushReady;
    wire doPop = popValid && popReady;

    // Wraps at DEPTH so odd depths work
    function automatic logic [PtrW-1:0] bump(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pushReady = count != CntW'(DEPTH);
    assign popValid = count != '0;
    assign popItem = slots[rdPtr];
    assign freeSlots = CntW'(DEPTH) - count;

    always_ff @(posedge clk) begin
        if (doPush && !flush)
            slots[wrPtr] <= pushItem;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (flush) begin  // Redirect drops everything queued
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush)
                wrPtr <= bump(wrPtr);
            if (doPop)
                rdPtr <= bump(rdPtr);
            count <= count + CntW'(doPush) - CntW'(doPop);
        end
    end

endmodule

/* verilog/regFile.sv */
`include "tenyr_cfg.svh"
`timescale 1ns/1ps

module regFile (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [3:0]             indexZ,
    input  logic [3:0]             indexX,
    input  logic [3:0]             indexY,
    input  logic [`TENYR_XLEN-1:0] nextPc,
    input  logic                   writeEn,
    input  logic [`TENYR_XLEN-1:0] writeData,
    output logic [`TENYR_XLEN-1:0] valueZ,
    output logic [`TENYR_XLEN-1:0] valueX,
    output logic [`TENYR_XLEN-1:0] valueY
);
    logic [`TENYR_XLEN-1:0] regs [1:14];  // r0 and r15 have no storage

    function automatic logic [`TENYR_XLEN-1:0] readReg(input logic [3:0] index);
        if (index == 4'h0)
            return '0;
        if (index == 4'hf)
            return nextPc;  // r15 is the pc of the next instruction
        return regs[index];
    endfunction

    always_comb begin
        valueZ = readReg(indexZ);
        valueX = readReg(indexX);
        valueY = readReg(indexY);
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++)
                regs[i] <= '0;
        end else if (writeEn && indexZ != 4'h0 && indexZ != 4'hf) begin
            regs[indexZ] <= writeData;
        end
    end

endmodule

/* verilog/tenyrCore.sv */
`include "tenyr_cfg.svh"
`timescale 1ns/1ps

module tenyrCore (
    input  logic                     clk,
    input  logic                     reset_n,
    output logic                     imArvalid,
    output logic [`TENYR_XLEN-1:0]   imAraddr,
    input  logic                     imArready,
    input  logic                     imRvalid,
    input  logic [`TENYR_XLEN-1:0]   imRdata,
    input  logic [1:0]               imRresp,
    output logic                     imRready,
    output logic                     dmAwvalid,
    output logic [`TENYR_XLEN-1:0]   dmAwaddr,
    input  logic                     dmAwready,
    output logic                     dmWvalid,
    output logic [`TENYR_XLEN-1:0]   dmWdata,
    output logic [`TENYR_XLEN/8-1:0] dmWstrb,
    input  logic                     dmWready,
    input  logic                     dmBvalid,
    input  logic [1:0]               dmBresp,
    output logic                     dmBready,
    output logic                     dmArvalid,
    output logic [`TENYR_XLEN-1:0]   dmAraddr,
    input  logic                     dmArready,
    input  logic                     dmRvalid,
    input  logic [`TENYR_XLEN-1:0]   dmRdata,
    input  logic [1:0]               dmRresp,
    output logic                     dmRready,
    output logic                     halt
);
    tenyrPkg::redirect_t                     redirect;
    tenyrPkg::queueItem_t                    pushItem;
    tenyrPkg::queueItem_t                    popItem;
    logic                                    pushValid;
    logic                                    pushReady;
    logic                                    popValid;
    logic                                    popReady;
    logic [$clog2(`TENYR_QUEUE_DEPTH+1)-1:0] freeSlots;
    logic [3:0]                              indexZ;
    logic [3:0]                              indexX;
    logic [3:0]                              indexY;
    logic [`TENYR_XLEN-1:0]                  nextPc;
    logic                                    writeEn;
    logic [`TENYR_XLEN-1:0]                  writeData;
    logic [`TENYR_XLEN-1:0]                  valueZ;
    logic [`TENYR_XLEN-1:0]                  valueX;
    logic [`TENYR_XLEN-1:0]                  valueY;

    fetchUnit fetch0 (.*);

    insnQueue queue0 (.flush(redirect.valid), .*);  // Branch empties the queue

    execUnit exec0 (.*);

    regFile regs0 (.*);

endmodule

/* verilog/tenyrPkg.sv */
`include "tenyr_cfg.svh"

package tenyrPkg;

    typedef enum logic [3:0] {
        orOp    = 4'h0,  // X | Y
        andOp   = 4'h1,  // X & Y
        addOp   = 4'h2,  // X + Y
        mulOp   = 4'h3,  // Low word of X * Y
        res4Op  = 4'h4,  // Reserved
        shlOp   = 4'h5,  // Logical left shift
        ltOp    = 4'h6,  // Signed less than
        eqOp    = 4'h7,
        gtOp    = 4'h8,  // Signed greater than
        andnOp  = 4'h9,  // X & ~Y
        xorOp   = 4'ha,
        subOp   = 4'hb,
        xnorOp  = 4'hc,
        shrOp   = 4'hd,  // Logical right shift
        neOp    = 4'he,
        res15Op = 4'hf   // Reserved
    } aluOp_t;

    // Instruction word as it sits in memory, msb first
    typedef struct packed {
        logic        illegalTop;
        logic        kind;     // Immediate becomes the right operand
        logic        storing;
        logic        deref;
        logic [3:0]  z;
        logic [3:0]  x;
        logic [3:0]  y;
        aluOp_t      op;
        logic [11:0] imm;      // Sign extended before use
    } insnFields_t;

    typedef struct packed {
        logic [`TENYR_XLEN-1:0] pc;    // Word address
        logic [`TENYR_XLEN-1:0] insn;
    } queueItem_t;

    typedef struct packed {
        logic                   valid;
        logic [`TENYR_XLEN-1:0] target;  // Word address
    } redirect_t;

endpackage

/* verilog/tenyr_cfg.svh */
`ifndef TENYR_CFG_SVH
`define TENYR_CFG_SVH

// Word address of the first fetched instruction
`define TENYR_RESET_VECTOR 32'h0000_0000

// Entries in the instruction queue
`define TENYR_QUEUE_DEPTH 4

// Data and address width
`define TENYR_XLEN 32

`endif

/* vlog.f */
+incdir+verilog
verilog/tenyrPkg.sv
verilog/fetchUnit.sv
verilog/insnQueue.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/tenyrCore.sv
dv/tbClock.sv
dv/coreChk.sv
dv/coreTb.sv
